//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Cache geometry
`define LINE_BYTES 16
`define NUM_SETS 8
`define NUM_WAYS 2

// Backing line memory, MEM_LINES is a power of two
`define MEM_LINES 64
`define MEM_LATENCY 4
`define MEM_INIT_KEY 32'h5a5a0000

// Derived widths
`define OFFSET_BITS ($clog2(`LINE_BYTES))
`define SET_BITS ($clog2(`NUM_SETS))
`define WAY_BITS ($clog2(`NUM_WAYS))
`define TAG_BITS (32 - `OFFSET_BITS - `SET_BITS)
`define WORD_BITS (`OFFSET_BITS - 2)
`define LINE_BITS (`LINE_BYTES * 8)

`endif

//--- rtl/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

  typedef logic [`WAY_BITS-1:0] way_t;
  typedef logic [`WAY_BITS:0] lru_rank_t;   // 0 is most recent

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_RD,
    MEM_WR
  } mem_op_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_BACK,
    FILL
  } ctrl_state_t;

  typedef enum logic {
    M_IDLE,
    M_BUSY
  } mem_state_t;

  // Word address split into cache fields
  typedef struct packed {
    logic [`TAG_BITS-1:0]  tag;
    logic [`SET_BITS-1:0]  set;
    logic [`WORD_BITS-1:0] word;
    logic [1:0]            byte_sel;  // Always zero for word accesses
  } addr_fields_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] wdata;
  } cache_req_t;

  typedef struct packed {
    mem_op_t               op;
    logic [31:0]           line_addr;  // Byte address shifted down by the offset
    logic [`LINE_BITS-1:0] data;
  } mem_req_t;

endpackage

//--- rtl/way_select.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module way_select import cache_pkg::*; (
  input  logic [`NUM_WAYS-1:0]                set_valid,
  input  logic [`NUM_WAYS-1:0][`TAG_BITS-1:0] set_tag,
  input  lru_rank_t [`NUM_WAYS-1:0]           set_rank,
  input  logic [`TAG_BITS-1:0]                tag,
  output logic                                hit,
  output way_t                                hit_way,
  output way_t                                victim_way
);

  logic any_invalid;

  assign any_invalid = ~&set_valid;

  // Tag compare over valid ways
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (set_valid[w] && set_tag[w] == tag) begin
        hit = 1'b1;
        hit_way = way_t'(w);
      end
    end
  end

  // Cold miss takes the lowest invalid way, otherwise the LRU way
  always_comb begin
    victim_way = '0;
    if (any_invalid) begin
      for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
        if (!set_valid[w])
          victim_way = way_t'(w);  // Lowest index wins
      end
    end else begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        if (set_rank[w] == lru_rank_t'(`NUM_WAYS - 1))
          victim_way = way_t'(w);
      end
    end
  end

endmodule

//--- rtl/cache_store.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_store import cache_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_req_t            req,
  input  logic                  store_en,
  input  logic                  touch_en,
  input  logic                  fill_en,
  input  logic [`LINE_BITS-1:0] fill_data,
  output logic                  hit,
  output logic                  victim_dirty,
  output logic [31:0]           victim_line_addr,
  output logic [`LINE_BITS-1:0] victim_data,
  output logic [31:0]           dout
);

  addr_fields_t f;
  way_t         hit_way;
  way_t         victim_way;
  way_t         upd_way;  // Way made most recent this cycle

  logic [`NUM_WAYS-1:0]                  valid_q [`NUM_SETS];
  logic [`NUM_WAYS-1:0]                  dirty_q [`NUM_SETS];
  lru_rank_t [`NUM_WAYS-1:0]             rank_q  [`NUM_SETS];
  logic [`NUM_WAYS-1:0][`TAG_BITS-1:0]   tag_q   [`NUM_SETS];
  logic [`NUM_WAYS-1:0][`LINE_BITS-1:0]  data_q  [`NUM_SETS];

  assign f = addr_fields_t'(req.addr);

  way_select u_way_select (
    .set_valid  (valid_q[f.set]),
    .set_tag    (tag_q[f.set]),
    .set_rank   (rank_q[f.set]),
    .tag        (f.tag),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  assign upd_way = fill_en ? victim_way : hit_way;

  assign dout = data_q[f.set][hit_way][f.word*32 +: 32];
  assign victim_dirty = dirty_q[f.set][victim_way];
  assign victim_line_addr = {{`OFFSET_BITS{1'b0}}, tag_q[f.set][victim_way], f.set};
  assign victim_data = data_q[f.set][victim_way];

  // Control state: valid, dirty and LRU ranks
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        for (int w = 0; w < `NUM_WAYS; w++)
          rank_q[s][w] <= lru_rank_t'(`NUM_WAYS - 1);  // All start oldest
      end
    end else begin
      if (touch_en || fill_en) begin
        // Ways younger than the touched one age by one
        for (int w = 0; w < `NUM_WAYS; w++) begin
          if (rank_q[f.set][w] < rank_q[f.set][upd_way])
            rank_q[f.set][w] <= rank_q[f.set][w] + 1'b1;
        end
        rank_q[f.set][upd_way] <= '0;
      end
      if (store_en)
        dirty_q[f.set][hit_way] <= 1'b1;
      if (fill_en) begin
        valid_q[f.set][victim_way] <= 1'b1;
        dirty_q[f.set][victim_way] <= 1'b0;  // Fresh copy of memory
      end
    end
  end

  // Tag and data payload
  always_ff @(posedge clk) begin
    if (store_en)
      data_q[f.set][hit_way][f.word*32 +: 32] <= req.wdata;
    if (fill_en) begin
      tag_q[f.set][victim_way] <= f.tag;
      data_q[f.set][victim_way] <= fill_data;
    end
  end

endmodule

//--- rtl/cache_controller.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_controller import cache_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  is_input_valid,
  input  cache_req_t            req,
  input  logic                  hit,
  input  logic                  victim_dirty,
  input  logic [31:0]           victim_line_addr,
  input  logic [`LINE_BITS-1:0] victim_data,
  input  logic                  mem_done,
  output logic                  is_ready,
  output logic                  is_output_valid,
  output logic                  store_en,
  output logic                  touch_en,
  output logic                  fill_en,
  output mem_req_t              mem_req
);

  ctrl_state_t state;
  logic        issued;  // Memory request of this state already sent
  logic        lookup;

  assign is_ready = (state == IDLE);
  assign lookup = is_ready && is_input_valid;
  assign is_output_valid = lookup && hit;
  assign touch_en = lookup && hit;
  assign store_en = lookup && hit && req.write;
  assign fill_en = (state == FILL) && mem_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      issued <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          issued <= 1'b0;
          if (lookup && !hit)
            state <= victim_dirty ? WRITE_BACK : FILL;  // Evict dirty line first
        end
        WRITE_BACK: begin
          issued <= !mem_done;
          if (mem_done)
            state <= FILL;
        end
        FILL: begin
          issued <= !mem_done;
          if (mem_done)
            state <= IDLE;  // Request then completes as a hit
        end
        default: begin
          state <= IDLE;
          issued <= 1'b0;
        end
      endcase
    end
  end

  // One-cycle request pulse in the first cycle of each memory state
  always_comb begin
    mem_req.op = MEM_NONE;
    mem_req.line_addr = req.addr >> `OFFSET_BITS;
    mem_req.data = victim_data;
    if (state == WRITE_BACK && !issued) begin
      mem_req.op = MEM_WR;
      mem_req.line_addr = victim_line_addr;
    end
    if (state == FILL && !issued)
      mem_req.op = MEM_RD;
  end

endmodule

//--- rtl/line_memory.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module line_memory import cache_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  mem_req_t              mem_req,
  output logic                  mem_done,
  output logic [`LINE_BITS-1:0] mem_rdata
);

  localparam int IDX_BITS = $clog2(`MEM_LINES);
  localparam int CNT_BITS = $clog2(`MEM_LATENCY) + 1;

  mem_state_t            state;
  mem_req_t              pend;   // Latched request
  logic [CNT_BITS-1:0]   cnt;
  logic [IDX_BITS-1:0]   idx;
  logic [`LINE_BITS-1:0] mem [`MEM_LINES];

  assign idx = pend.line_addr[IDX_BITS-1:0];  // Line address wraps modulo MEM_LINES
  assign mem_done = (state == M_BUSY) && (cnt == CNT_BITS'(`MEM_LATENCY - 1));
  assign mem_rdata = mem[idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= M_IDLE;
      cnt <= '0;
      // Each word holds its byte address XOR the init key
      for (int l = 0; l < `MEM_LINES; l++) begin
        for (int w = 0; w < `LINE_BYTES / 4; w++)
          mem[l][w*32 +: 32] <= 32'(l * `LINE_BYTES + w * 4) ^ `MEM_INIT_KEY;
      end
    end else begin
      case (state)
        M_IDLE: begin
          cnt <= '0;
          if (mem_req.op != MEM_NONE)
            state <= M_BUSY;
        end
        M_BUSY: begin
          if (mem_done) begin
            state <= M_IDLE;
            if (pend.op == MEM_WR)
              mem[idx] <= pend.data;  // Write lands on the done edge
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == M_IDLE && mem_req.op != MEM_NONE)
      pend <= mem_req;
  end

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_top import cache_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       is_input_valid,
  input  cache_req_t req,
  output logic       is_ready,
  output logic       is_output_valid,
  output logic       is_hit,
  output logic [31:0] dout
);

  logic                  victim_dirty;
  logic [31:0]           victim_line_addr;
  logic [`LINE_BITS-1:0] victim_data;
  logic                  store_en;
  logic                  touch_en;
  logic                  fill_en;
  mem_req_t              mem_req;
  logic                  mem_done;
  logic [`LINE_BITS-1:0] mem_rdata;

  cache_controller u_ctrl (
    .clk              (clk),
    .reset            (reset),
    .is_input_valid   (is_input_valid),
    .req              (req),
    .hit              (is_hit),
    .victim_dirty     (victim_dirty),
    .victim_line_addr (victim_line_addr),
    .victim_data      (victim_data),
    .mem_done         (mem_done),
    .is_ready         (is_ready),
    .is_output_valid  (is_output_valid),
    .store_en         (store_en),
    .touch_en         (touch_en),
    .fill_en          (fill_en),
    .mem_req          (mem_req)
  );

  cache_store u_store (
    .clk              (clk),
    .reset            (reset),
    .req              (req),
    .store_en         (store_en),
    .touch_en         (touch_en),
    .fill_en          (fill_en),
    .fill_data        (mem_rdata),
    .hit              (is_hit),
    .victim_dirty     (victim_dirty),
    .victim_line_addr (victim_line_addr),
    .victim_data      (victim_data),
    .dout             (dout)
  );

  line_memory u_mem (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_done  (mem_done),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- test/cache_ref_model.sv
`include "cache_macros.svh"

package cache_ref_model;

  localparam int WORDS_PER_LINE = `LINE_BYTES / 4;
  localparam int MEM_WORDS = `MEM_LINES * WORDS_PER_LINE;

  logic [31:0] flat_mem [MEM_WORDS];  // Architectural memory image
  bit          sh_valid [`NUM_SETS][`NUM_WAYS];
  bit          sh_dirty [`NUM_SETS][`NUM_WAYS];
  int          sh_tag   [`NUM_SETS][`NUM_WAYS];
  int          sh_rank  [`NUM_SETS][`NUM_WAYS];  // 0 is most recent

  function automatic void model_reset();
    for (int i = 0; i < MEM_WORDS; i++)
      flat_mem[i] = 32'(i * 4) ^ `MEM_INIT_KEY;
    for (int s = 0; s < `NUM_SETS; s++) begin
      for (int w = 0; w < `NUM_WAYS; w++) begin
        sh_valid[s][w] = 1'b0;
        sh_dirty[s][w] = 1'b0;
        sh_tag[s][w] = 0;
        sh_rank[s][w] = `NUM_WAYS - 1;
      end
    end
  endfunction

  // Predicts the lookup result, then applies the access to the shadow state
  function automatic void model_access(input logic [31:0] addr, input logic write,
                                       input logic [31:0] wdata, output bit hit,
                                       output bit victim_dirty, output logic [31:0] rdata);
    int line;
    int set;
    int tag;
    int word;
    int way;
    int old_rank;
    line = int'(addr / `LINE_BYTES);
    set = line % `NUM_SETS;
    tag = line / `NUM_SETS;
    word = int'(addr >> 2) % MEM_WORDS;
    hit = 1'b0;
    victim_dirty = 1'b0;
    way = -1;
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (sh_valid[set][w] && sh_tag[set][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
        if (!sh_valid[set][w])
          way = w;  // Invalid ways fill first
      end
      if (way < 0) begin
        for (int w = 0; w < `NUM_WAYS; w++) begin
          if (sh_rank[set][w] == `NUM_WAYS - 1)
            way = w;
        end
      end
      victim_dirty = sh_valid[set][way] && sh_dirty[set][way];
      sh_valid[set][way] = 1'b1;
      sh_dirty[set][way] = 1'b0;
      sh_tag[set][way] = tag;
    end
    // Used way becomes most recent
    old_rank = sh_rank[set][way];
    for (int w = 0; w < `NUM_WAYS; w++) begin
      if (sh_rank[set][w] < old_rank)
        sh_rank[set][w]++;
    end
    sh_rank[set][way] = 0;
    rdata = flat_mem[word];
    if (write) begin
      flat_mem[word] = wdata;
      sh_dirty[set][way] = 1'b1;
    end
  endfunction

endpackage

//--- test/cache_tb.sv
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_tb import cache_pkg::*, cache_ref_model::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM = 400;
  localparam int NUM_DIRECTED = 4;
  localparam int MAX_GAP = 1;
  localparam int TAGS_PER_SET = `MEM_LINES / `NUM_SETS;
  localparam int CYCLE_LIMIT = (NUM_RANDOM + NUM_DIRECTED) * (2 * `MEM_LATENCY + 4 + MAX_GAP)
                               + RESET_CYCLES;

  logic        clk = 1'b0;
  logic        reset;
  logic        is_input_valid;
  cache_req_t  req;
  logic        is_ready;
  logic        is_output_valid;
  logic        is_hit;
  logic [31:0] dout;

  int seed = 32'h20c3;
  int checks = 0;
  int errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  int cycle_count = 0;

  cache_top dut (
    .clk             (clk),
    .reset           (reset),
    .is_input_valid  (is_input_valid),
    .req             (req),
    .is_ready        (is_ready),
    .is_output_valid (is_output_valid),
    .is_hit          (is_hit),
    .dout            (dout)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the cache stopped answering", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_hit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s finished: %0d checks, %0d errors", name,
             checks - test_checks, errors - test_errors);
    test_checks = checks;
    test_errors = errors;
  endtask

  function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
    return 32'((tag * `NUM_SETS + set) * `LINE_BYTES + word * 4);
  endfunction

  // Holds one request until the cache answers, then checks it
  task automatic do_request(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata);
    bit          exp_hit;
    bit          exp_dirty;
    logic [31:0] exp_word;
    logic        first_hit;
    int          lat;
    int          exp_lat;
    model_access(addr, write, wdata, exp_hit, exp_dirty, exp_word);
    exp_lat = exp_hit ? 0 : (exp_dirty ? 2 * `MEM_LATENCY + 3 : `MEM_LATENCY + 2);
    @(negedge clk);
    req.addr = addr;
    req.write = write;
    req.wdata = wdata;
    is_input_valid = 1'b1;
    #10;
    first_hit = is_hit;  // Lookup result in the first cycle
    lat = 0;
    while (!is_output_valid) begin
      @(negedge clk);
      #10;
      lat++;
    end
    check_hit("is_hit", first_hit, exp_hit);
    check_latency("is_output_valid latency", lat, exp_lat);
    if (!write)
      check_word("dout", dout, exp_word);
  endtask

  initial begin
    int          tag;
    int          set;
    int          word;
    logic        write;
    logic [31:0] wdata;
    reset = 1'b1;
    is_input_valid = 1'b0;
    req = '0;
    model_reset();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    #10;
    check_hit("is_ready", is_ready, 1'b1);
    check_hit("is_output_valid", is_output_valid, 1'b0);
    report_test("reset");

    // Dirty line pushed out by two other tags, then read back
    do_request(make_addr(0, 3, 1), 1'b1, 32'hc0de0001);
    do_request(make_addr(1, 3, 0), 1'b0, 32'h0);
    do_request(make_addr(2, 3, 2), 1'b0, 32'h0);
    do_request(make_addr(0, 3, 1), 1'b0, 32'h0);
    report_test("write_back");

    for (int i = 0; i < NUM_RANDOM; i++) begin
      if ($unsigned($random(seed)) % 4 == 0)
        tag = int'($unsigned($random(seed)) % TAGS_PER_SET);
      else
        tag = int'($unsigned($random(seed)) % 3);  // Three hot tags per set
      set = int'($unsigned($random(seed)) % `NUM_SETS);
      word = int'($unsigned($random(seed)) % WORDS_PER_LINE);
      write = ($unsigned($random(seed)) % 100) < 40;
      wdata = $random(seed);
      do_request(make_addr(tag, set, word), write, wdata);
      if ($unsigned($random(seed)) % 4 == 0) begin
        @(negedge clk);
        is_input_valid = 1'b0;  // Idle cycle between requests
      end
    end
    @(negedge clk);
    is_input_valid = 1'b0;
    report_test("random");

    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
rtl/cache_pkg.sv
rtl/way_select.sv
rtl/cache_store.sv
rtl/cache_controller.sv
rtl/line_memory.sv
rtl/cache_top.sv
test/cache_ref_model.sv
test/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module cache_tb -f files.f -o cache_sim
./obj_dir/cache_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi
